// ==== design/mem_types_pkg.sv ====
package mem_types_pkg;

    typedef logic [31:0]  addr_t;    // byte address
    typedef logic [31:0]  word_t;    // core data word
    typedef logic [3:0]   wmask_t;   // one enable per byte lane
    typedef logic [255:0] line_t;    // full cache line
    typedef logic [63:0]  beat_t;    // one burst beat
    typedef logic [22:0]  tag_t;     // addr[31:9]
    typedef logic [3:0]   index_t;   // addr[8:5]
    typedef logic [2:0]   offset_t;  // addr[4:2], word in line

    localparam int NUM_SETS       = 16;
    localparam int WORDS_PER_LINE = 8;
    localparam int BEATS_PER_LINE = 4;

    typedef struct packed {
        addr_t  addr;   // byte address of the access
        logic   read;   // held until resp
        logic   write;  // held until resp
        wmask_t wmask;  // byte enables for writes
        word_t  wdata;
    } core_req_t;

    typedef struct packed {
        addr_t  addr;   // line aligned
        logic   read;
        logic   write;
        line_t  wdata;  // whole line on writeback
    } line_req_t;

    typedef enum logic [1:0] {IDLE, WRITEBACK, FILL, RESPOND} cache_state_t;
    typedef enum logic [1:0] {ARB_IDLE, ARB_ICACHE, ARB_DCACHE} arb_state_t;
    typedef enum logic [1:0] {B_IDLE, B_READ, B_WRITE, B_DONE} burst_state_t;

endpackage

// ==== design/line_cache.sv ====
module line_cache (
    input  logic                    clk,
    input  logic                    rst,
    input  mem_types_pkg::core_req_t core_req_i,    // from core port
    output mem_types_pkg::word_t    core_rdata_o,
    output logic                    core_resp_o,
    output mem_types_pkg::line_req_t line_req_o,    // to arbiter
    input  mem_types_pkg::line_t    line_rdata_i,
    input  logic                    line_resp_i
);
    import mem_types_pkg::*;

    cache_state_t state_q;

    tag_t   tag_q  [NUM_SETS];          // per-set tag
    line_t  data_q [NUM_SETS];          // per-set line data
    logic [NUM_SETS-1:0] valid_q;
    logic [NUM_SETS-1:0] dirty_q;
    word_t  rdata_q;                    // word returned with resp

    tag_t    tag;
    index_t  idx;
    offset_t off;
    logic    req;
    logic    hit;
    logic    victim_dirty;
    logic    hit_access;                // hit taken in IDLE
    logic    fill_done;                 // refill beat set arrived

    line_t   src_line;
    word_t [WORDS_PER_LINE-1:0] src_words;
    word_t [WORDS_PER_LINE-1:0] upd_words;
    word_t   sel_word;
    word_t   merged_word;
    logic    line_we;

    // address split
    assign tag = core_req_i.addr[31:9];
    assign idx = core_req_i.addr[8:5];
    assign off = core_req_i.addr[4:2];

    assign req          = core_req_i.read | core_req_i.write;
    assign hit          = valid_q[idx] && (tag_q[idx] == tag);
    assign victim_dirty = valid_q[idx] && dirty_q[idx];
    assign hit_access   = (state_q == IDLE) && req && hit;
    assign fill_done    = (state_q == FILL) && line_resp_i;

    // word select and byte merge, on the stored line or the incoming fill
    always_comb begin
        src_line    = (state_q == FILL) ? line_rdata_i : data_q[idx];
        src_words   = src_line;
        sel_word    = src_words[off];
        merged_word = sel_word;
        for (int b = 0; b < $bits(wmask_t); b++) begin
            if (core_req_i.wmask[b]) begin
                merged_word[8*b +: 8] = core_req_i.wdata[8*b +: 8];  // new byte lane
            end
        end
        upd_words = src_words;
        if (core_req_i.write) begin
            upd_words[off] = merged_word;   // only the addressed word changes
        end
    end

    assign line_we = (hit_access && core_req_i.write) || fill_done;

    // line request toward the arbiter
    always_comb begin
        line_req_o.read  = (state_q == FILL);
        line_req_o.write = (state_q == WRITEBACK);
        line_req_o.wdata = data_q[idx];                     // victim line
        if (state_q == WRITEBACK) begin
            line_req_o.addr = {tag_q[idx], idx, 5'b0};      // victim's own address
        end else begin
            line_req_o.addr = {tag, idx, 5'b0};
        end
    end

    assign core_resp_o  = (state_q == RESPOND);
    assign core_rdata_o = rdata_q;

    // storage arrays
    always_ff @(posedge clk) begin
        if (line_we) begin
            data_q[idx] <= upd_words;
        end
        if (fill_done) begin
            tag_q[idx] <= tag;
        end
        if (hit_access || fill_done) begin
            rdata_q <= sel_word;                            // read data for RESPOND
        end
    end

    // control FSM with valid and dirty bits
    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= IDLE;
            valid_q <= '0;
            dirty_q <= '0;
        end else begin
            case (state_q)
                IDLE: begin
                    if (req) begin
                        if (hit) begin
                            if (core_req_i.write) begin
                                dirty_q[idx] <= 1'b1;       // write hit
                            end
                            state_q <= RESPOND;
                        end else if (victim_dirty) begin
                            state_q <= WRITEBACK;
                        end else begin
                            state_q <= FILL;
                        end
                    end
                end
                WRITEBACK: begin
                    if (line_resp_i) begin
                        dirty_q[idx] <= 1'b0;               // victim now clean in memory
                        state_q      <= FILL;
                    end
                end
                FILL: begin
                    if (line_resp_i) begin
                        valid_q[idx] <= 1'b1;
                        dirty_q[idx] <= core_req_i.write;   // write miss merged on fill
                        state_q      <= RESPOND;
                    end
                end
                RESPOND: state_q <= IDLE;
                default: state_q <= IDLE;
            endcase
        end
    end

endmodule

// ==== design/mem_arbiter.sv ====
module mem_arbiter (
    input  logic                     clk,
    input  logic                     rst,
    input  mem_types_pkg::line_req_t icache_req_i,
    output mem_types_pkg::line_t     icache_rdata_o,
    output logic                     icache_resp_o,
    input  mem_types_pkg::line_req_t dcache_req_i,
    output mem_types_pkg::line_t     dcache_rdata_o,
    output logic                     dcache_resp_o,
    output mem_types_pkg::line_req_t pmem_req_o,     // to burst adapter
    input  mem_types_pkg::line_t     pmem_rdata_i,
    input  logic                     pmem_resp_i
);
    import mem_types_pkg::*;

    arb_state_t state_q;
    logic       icache_want;
    logic       dcache_want;

    assign icache_want = icache_req_i.read | icache_req_i.write;
    assign dcache_want = dcache_req_i.read | dcache_req_i.write;

    // grant FSM, data side wins ties
    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= ARB_IDLE;
        end else begin
            case (state_q)
                ARB_IDLE: begin
                    if (dcache_want) begin
                        state_q <= ARB_DCACHE;
                    end else if (icache_want) begin
                        state_q <= ARB_ICACHE;
                    end
                end
                ARB_ICACHE,
                ARB_DCACHE: begin
                    if (pmem_resp_i) begin
                        state_q <= ARB_IDLE;    // release after the line completes
                    end
                end
                default: state_q <= ARB_IDLE;
            endcase
        end
    end

    // pass through only the granted request
    always_comb begin
        case (state_q)
            ARB_DCACHE: pmem_req_o = dcache_req_i;
            ARB_ICACHE: pmem_req_o = icache_req_i;
            default:    pmem_req_o = '0;        // nothing toward memory while idle
        endcase
    end

    assign icache_rdata_o = pmem_rdata_i;
    assign dcache_rdata_o = pmem_rdata_i;
    assign icache_resp_o  = pmem_resp_i && (state_q == ARB_ICACHE);  // holder only
    assign dcache_resp_o  = pmem_resp_i && (state_q == ARB_DCACHE);

endmodule

// ==== design/line_burst_adapter.sv ====
module line_burst_adapter (
    input  logic                     clk,
    input  logic                     rst,
    input  mem_types_pkg::line_req_t line_req_i,     // from arbiter
    output mem_types_pkg::line_t     line_rdata_o,
    output logic                     line_resp_o,
    output mem_types_pkg::addr_t     bmem_address_o, // burst memory side
    output logic                     bmem_read_o,
    output logic                     bmem_write_o,
    output mem_types_pkg::beat_t     bmem_wdata_o,
    input  mem_types_pkg::beat_t     bmem_rdata_i,
    input  logic                     bmem_resp_i
);
    import mem_types_pkg::*;

    burst_state_t state_q;
    logic [$clog2(BEATS_PER_LINE)-1:0] beat_q;   // beats done so far
    addr_t        addr_q;                        // line address held for the burst
    line_t        line_q;                        // shift register for beats
    logic         last_beat;

    assign last_beat = &beat_q;                  // counter at final beat

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= B_IDLE;
            beat_q  <= '0;
        end else begin
            case (state_q)
                B_IDLE: begin
                    beat_q <= '0;
                    if (line_req_i.read) begin
                        state_q <= B_READ;
                    end else if (line_req_i.write) begin
                        state_q <= B_WRITE;
                    end
                end
                B_READ,
                B_WRITE: begin
                    if (bmem_resp_i) begin
                        beat_q <= beat_q + 1'b1;
                        if (last_beat) begin
                            state_q <= B_DONE;
                        end
                    end
                end
                B_DONE:  state_q <= B_IDLE;  // one-cycle resp to arbiter
                default: state_q <= B_IDLE;
            endcase
        end
    end

    // address and line payload
    always_ff @(posedge clk) begin
        if (state_q == B_IDLE) begin
            addr_q <= line_req_i.addr;                   // line aligned by the cache
            line_q <= line_req_i.wdata;                  // loaded for writes, replaced on reads
        end else if (bmem_resp_i && (state_q == B_READ)) begin
            line_q <= {bmem_rdata_i, line_q[255:64]};    // lowest beat ends at bottom
        end else if (bmem_resp_i && (state_q == B_WRITE)) begin
            line_q <= line_q >> $bits(beat_t);           // next beat to bottom
        end
    end

    assign bmem_address_o = addr_q;
    assign bmem_read_o    = (state_q == B_READ);
    assign bmem_write_o   = (state_q == B_WRITE);
    assign bmem_wdata_o   = line_q[63:0];
    assign line_rdata_o   = line_q;
    assign line_resp_o    = (state_q == B_DONE);

endmodule

// ==== design/mem_subsys.sv ====
module mem_subsys (
    input  logic                     clk,
    input  logic                     rst,
    input  mem_types_pkg::core_req_t imem_req_i,     // instruction port
    output mem_types_pkg::word_t     imem_rdata_o,
    output logic                     imem_resp_o,
    input  mem_types_pkg::core_req_t dmem_req_i,     // data port
    output mem_types_pkg::word_t     dmem_rdata_o,
    output logic                     dmem_resp_o,
    output mem_types_pkg::addr_t     bmem_address_o,
    output logic                     bmem_read_o,
    output logic                     bmem_write_o,
    output mem_types_pkg::beat_t     bmem_wdata_o,
    input  mem_types_pkg::beat_t     bmem_rdata_i,
    input  logic                     bmem_resp_i
);
    import mem_types_pkg::*;

    line_req_t icache_line_req;   // icache -> arbiter
    line_t     icache_line_rdata; // icache <- arbiter
    logic      icache_line_resp;
    line_req_t dcache_line_req;   // dcache -> arbiter
    line_t     dcache_line_rdata; // dcache <- arbiter
    logic      dcache_line_resp;
    line_req_t pmem_req;          // arbiter -> adapter
    line_t     pmem_rdata;        // arbiter <- adapter
    logic      pmem_resp;

    line_cache icache (
        .clk, .rst,
        .core_req_i   (imem_req_i),
        .core_rdata_o (imem_rdata_o),
        .core_resp_o  (imem_resp_o),
        .line_req_o   (icache_line_req),
        .line_rdata_i (icache_line_rdata),
        .line_resp_i  (icache_line_resp)
    );

    line_cache dcache (
        .clk, .rst,
        .core_req_i   (dmem_req_i),
        .core_rdata_o (dmem_rdata_o),
        .core_resp_o  (dmem_resp_o),
        .line_req_o   (dcache_line_req),
        .line_rdata_i (dcache_line_rdata),
        .line_resp_i  (dcache_line_resp)
    );

    mem_arbiter arbiter (
        .clk, .rst,
        .icache_req_i   (icache_line_req),
        .icache_rdata_o (icache_line_rdata),
        .icache_resp_o  (icache_line_resp),
        .dcache_req_i   (dcache_line_req),
        .dcache_rdata_o (dcache_line_rdata),
        .dcache_resp_o  (dcache_line_resp),
        .pmem_req_o     (pmem_req),
        .pmem_rdata_i   (pmem_rdata),
        .pmem_resp_i    (pmem_resp)
    );

    line_burst_adapter burst_adapter (
        .clk, .rst,
        .line_req_i     (pmem_req),
        .line_rdata_o   (pmem_rdata),
        .line_resp_o    (pmem_resp),
        .bmem_address_o (bmem_address_o),
        .bmem_read_o    (bmem_read_o),
        .bmem_write_o   (bmem_write_o),
        .bmem_wdata_o   (bmem_wdata_o),
        .bmem_rdata_i   (bmem_rdata_i),
        .bmem_resp_i    (bmem_resp_i)
    );

endmodule

// ==== testbench/burst_mem_model.sv ====
module burst_mem_model (
    input  logic                 clk,
    input  logic                 rst,
    input  mem_types_pkg::addr_t address_i,  // line address, held for the burst
    input  logic                 read_i,
    input  logic                 write_i,
    input  mem_types_pkg::beat_t wdata_i,
    output mem_types_pkg::beat_t rdata_o,
    output logic                 resp_o      // one pulse per beat
);
    timeunit 1ns;
    timeprecision 1ps;
    import mem_types_pkg::*;

    word_t      mem [addr_t];   // only words written by bursts
    logic       gap_q;          // wait cycle before the next beat
    logic       done_q;         // all four beats given
    logic [1:0] beat_q;
    addr_t      beat_addr;

    assign beat_addr = address_i + {27'b0, beat_q, 3'b0};

    function automatic word_t load_word(addr_t a);
        if (mem.exists(a)) begin
            return mem[a];
        end
        return a ^ 32'hA5A5_0000;       // untouched memory pattern
    endfunction

    always @(posedge clk) begin
        if (rst || !(read_i || write_i)) begin
            resp_o  <= 1'b0;
            rdata_o <= '0;
            gap_q   <= 1'b0;
            done_q  <= 1'b0;
            beat_q  <= '0;
        end else if (resp_o) begin
            resp_o <= 1'b0;
            if (write_i) begin
                mem[beat_addr]         = wdata_i[31:0];   // low word first
                mem[beat_addr + 32'd4] = wdata_i[63:32];
            end
            beat_q <= beat_q + 2'd1;
            done_q <= (beat_q == 2'd3);
            gap_q  <= 1'b1;                               // this cycle is the gap
        end else if (!done_q) begin
            if (gap_q) begin
                resp_o  <= 1'b1;
                rdata_o <= {load_word(beat_addr + 32'd4), load_word(beat_addr)};
            end else begin
                gap_q <= 1'b1;
            end
        end
    end

endmodule

// ==== testbench/mem_subsys_checker.sv ====
module mem_subsys_checker (
    input logic                      clk,
    input logic                      rst,
    input mem_types_pkg::core_req_t  imem_req_i,
    input logic                      imem_resp_i,
    input mem_types_pkg::core_req_t  dmem_req_i,
    input logic                      dmem_resp_i,
    input mem_types_pkg::addr_t      bmem_address_i,
    input logic                      bmem_read_i,
    input logic                      bmem_write_i
);
    timeunit 1ns;
    timeprecision 1ps;
    import mem_types_pkg::*;

    int   fail_count = 0;   // read by the testbench at the end
    logic bmem_busy;
    logic imem_held;
    logic dmem_held;

    assign bmem_busy  = bmem_read_i | bmem_write_i;
    assign imem_held  = imem_req_i.read | imem_req_i.write;
    assign dmem_held  = dmem_req_i.read | dmem_req_i.write;

    excl_a: assert property (@(posedge clk) disable iff (rst) !(bmem_read_i && bmem_write_i))
        else begin
            fail_count = fail_count + 1;
            $error("bmem read and write high together");
        end

    align_a: assert property (@(posedge clk) disable iff (rst)
        bmem_busy |-> (bmem_address_i[4:0] == 5'b0))
        else begin
            fail_count = fail_count + 1;
            $error("bmem address not line aligned");
        end

    stable_a: assert property (@(posedge clk) disable iff (rst)
        (bmem_busy && $past(bmem_busy)) |-> $stable(bmem_address_i))
        else begin
            fail_count = fail_count + 1;
            $error("bmem address moved during a burst");
        end

    // resp is a single cycle and only answers a request held before and at it
    iresp_a: assert property (@(posedge clk) disable iff (rst)
        imem_resp_i |-> (imem_held && $past(imem_held)) ##1 !imem_resp_i)
        else begin
            fail_count = fail_count + 1;
            $error("bad imem resp pulse");
        end

    dresp_a: assert property (@(posedge clk) disable iff (rst)
        dmem_resp_i |-> (dmem_held && $past(dmem_held)) ##1 !dmem_resp_i)
        else begin
            fail_count = fail_count + 1;
            $error("bad dmem resp pulse");
        end

    quiet_a: assert property (@(posedge clk) $fell(rst) |-> !bmem_busy ##1 !bmem_busy)
        else begin
            fail_count = fail_count + 1;
            $error("bmem active right after reset");
        end

endmodule

// ==== testbench/mem_subsys_tb.sv ====
module mem_subsys_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import mem_types_pkg::*;

    localparam int TIMEOUT_CYCLES = 200;
    localparam int HIT_CYCLES     = 2;     // drive edge, sample edge, resp edge
    localparam int RANDOM_OPS     = 200;

    logic      clk;
    logic      rst;
    core_req_t imem_req;
    word_t     imem_rdata;
    logic      imem_resp;
    core_req_t dmem_req;
    word_t     dmem_rdata;
    logic      dmem_resp;
    addr_t     bmem_address;
    logic      bmem_read;
    logic      bmem_write;
    beat_t     bmem_wdata;
    beat_t     bmem_rdata;
    logic      bmem_resp;

    word_t       shadow [addr_t];   // words written so far
    int          errors = 0;
    int          checks = 0;
    int          test_start = 0;    // error count when the test began
    int          cycles;
    int          cycles_d;
    integer      seed = 18;
    logic [31:0] r;
    addr_t       addr;
    word_t       wdata;

    mem_subsys mem_subsys_i (
        .clk, .rst,
        .imem_req_i     (imem_req),
        .imem_rdata_o   (imem_rdata),
        .imem_resp_o    (imem_resp),
        .dmem_req_i     (dmem_req),
        .dmem_rdata_o   (dmem_rdata),
        .dmem_resp_o    (dmem_resp),
        .bmem_address_o (bmem_address),
        .bmem_read_o    (bmem_read),
        .bmem_write_o   (bmem_write),
        .bmem_wdata_o   (bmem_wdata),
        .bmem_rdata_i   (bmem_rdata),
        .bmem_resp_i    (bmem_resp)
    );

    burst_mem_model bmem (
        .clk, .rst,
        .address_i (bmem_address),
        .read_i    (bmem_read),
        .write_i   (bmem_write),
        .wdata_i   (bmem_wdata),
        .rdata_o   (bmem_rdata),
        .resp_o    (bmem_resp)
    );

    bind mem_subsys mem_subsys_checker checker_i (
        .clk, .rst,
        .imem_req_i     (imem_req_i),
        .imem_resp_i    (imem_resp_o),
        .dmem_req_i     (dmem_req_i),
        .dmem_resp_i    (dmem_resp_o),
        .bmem_address_i (bmem_address_o),
        .bmem_read_i    (bmem_read_o),
        .bmem_write_i   (bmem_write_o)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;   // 20 ns period
    end

    function automatic word_t expected_word(addr_t a);
        if (shadow.exists(a)) begin
            return shadow[a];
        end
        return a ^ 32'hA5A5_0000;   // memory content before any write
    endfunction

    function automatic void apply_write(addr_t a, wmask_t mask, word_t data);
        word_t w;
        w = expected_word(a);
        for (int b = 0; b < 4; b++) begin
            if (mask[b]) begin
                w[8*b +: 8] = data[8*b +: 8];
            end
        end
        shadow[a] = w;
    endfunction

    // one core access, held until resp; reads are compared with the shadow
    task automatic access(input logic dport, input logic wr, input addr_t a,
                          input wmask_t mask, input word_t data, output int lat);
        core_req_t req;
        logic      seen;
        word_t     got;
        word_t     exp;
        req       = '0;
        req.addr  = a;
        req.read  = !wr;
        req.write = wr;
        req.wmask = mask;
        req.wdata = data;
        @(posedge clk);
        if (dport) begin
            dmem_req <= req;
        end else begin
            imem_req <= req;
        end
        lat  = 0;
        seen = 1'b0;
        while (!seen && lat < TIMEOUT_CYCLES) begin
            @(posedge clk);
            lat++;
            seen = dport ? dmem_resp : imem_resp;
        end
        got = dport ? dmem_rdata : imem_rdata;
        if (dport) begin
            dmem_req <= '0;        // dropped in the cycle after resp
        end else begin
            imem_req <= '0;
        end
        if (!seen) begin
            $display("no response on the %s port for address %h", dport ? "data" : "instr", a);
            errors++;
        end else if (wr) begin
            apply_write(a, mask, data);
        end else begin
            checks++;
            exp = expected_word(a);
            if (got !== exp) begin
                $display("FAILED %s: expected %h, got %h",
                         dport ? "dmem_rdata_o" : "imem_rdata_o", exp, got);
                errors++;
            end
        end
    endtask

    task automatic watch_first_burst(input addr_t exp);
        int   n;
        logic seen;
        n    = 0;
        seen = 1'b0;
        while (!seen && n < TIMEOUT_CYCLES) begin
            @(posedge clk);
            n++;
            seen = bmem_read || bmem_write;
        end
        checks++;
        if (!seen) begin
            $display("no bmem burst started after the two misses");
            errors++;
        end else if (bmem_address !== exp) begin
            $display("FAILED bmem_address_o: expected %h, got %h", exp, bmem_address);
            errors++;
        end
    endtask

    task automatic report_test(input string name);
        if (errors == test_start) begin
            $display("%s: passed", name);
        end else begin
            $display("%s: %0d error(s)", name, errors - test_start);
        end
        test_start = errors;
    endtask

    initial begin
        rst      = 1'b1;
        imem_req = '0;
        dmem_req = '0;
        repeat (5) @(posedge clk);
        rst <= 1'b0;

        access(1'b0, 1'b0, 32'h1000, '0, '0, cycles);   // line miss
        for (int w = 1; w < 8; w++) begin
            access(1'b0, 1'b0, 32'h1000 + 4 * w, '0, '0, cycles);
            checks++;
            if (cycles != HIT_CYCLES) begin
                $display("instr hit took %0d cycles instead of %0d", cycles, HIT_CYCLES);
                errors++;
            end
        end
        report_test("instruction miss then hits");

        access(1'b1, 1'b1, 32'h2000, 4'b0011, 32'h1111_2222, cycles);   // write miss
        access(1'b1, 1'b0, 32'h2000, '0, '0, cycles);
        access(1'b1, 1'b1, 32'h2004, 4'b1100, 32'hCAFE_0000, cycles);
        access(1'b1, 1'b1, 32'h2008, 4'b0100, 32'h0077_0000, cycles);
        access(1'b1, 1'b0, 32'h2004, '0, '0, cycles);
        access(1'b1, 1'b0, 32'h2008, '0, '0, cycles);
        report_test("partial byte writes");

        access(1'b1, 1'b1, 32'h2040, 4'hF, 32'hDEAD_BEEF, cycles);
        access(1'b1, 1'b0, 32'h2240, '0, '0, cycles);    // same set, other tag
        access(1'b1, 1'b0, 32'h2040, '0, '0, cycles);    // refill from memory
        report_test("dirty eviction and refill");

        fork
            access(1'b0, 1'b0, 32'h1100, '0, '0, cycles);
            access(1'b1, 1'b0, 32'h3064, '0, '0, cycles_d);   // clean set, plain fill
            watch_first_burst(32'h3060);                  // data side wins
        join
        report_test("simultaneous misses");

        for (int n = 0; n < RANDOM_OPS; n++) begin
            r    = $random(seed);
            addr = 32'h4000 + {21'b0, r[5:0], r[8:6], 2'b00};   // 64 lines, 4 tags per set
            if (r[1:0] == 2'b11) begin
                access(1'b0, 1'b0, addr, '0, '0, cycles);       // lines never written
            end else begin
                wdata = $random(seed);
                access(1'b1, r[9], addr, r[13:10], wdata, cycles);
            end
        end
        report_test("random traffic");

        repeat (5) @(posedge clk);
        errors = errors + mem_subsys_i.checker_i.fail_count;
        $display("%0d checks, %0d errors, %0d from assertions",
                 checks, errors, mem_subsys_i.checker_i.fail_count);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// ==== mem_subsys.f ====
design/mem_types_pkg.sv
design/line_cache.sv
design/mem_arbiter.sv
design/line_burst_adapter.sv
design/mem_subsys.sv
testbench/burst_mem_model.sv
testbench/mem_subsys_checker.sv
testbench/mem_subsys_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build with Verilator, run, then judge the run by its log
rm -f sim.log
verilator --binary --timing --assert --top-module mem_subsys_tb \
    -f mem_subsys.f -o mem_subsys_sim \
    && ./obj_dir/mem_subsys_sim +verilator+error+limit+1000 > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "Test FAILED" sim.log && exit 1
grep -q "Test OK" sim.log || exit 1
exit 0
